/* verilog/cdbus_cfg.svh */
`ifndef CDBUS_CFG_SVH
`define CDBUS_CFG_SVH

`define CD_VERSION      8'h0e
`define CD_BUF_AW       8           // 256 bytes per buffer

`define CD_DIV_RESET    16'd346     // bit period is div + 1 clocks
`define CD_IDLE_RESET   8'd10       // idle bit times before bus_idle
`define CD_FILTER_RESET 8'hff

`endif

/* verilog/cd_reg_pkg.sv */
package cd_reg_pkg;

    typedef enum logic [3:0] {
        REG_VERSION   = 4'h0,
        REG_DIV       = 4'h1,
        REG_IDLE_WAIT = 4'h2,
        REG_FILTER    = 4'h3,
        REG_INT_FLAG  = 4'h4,
        REG_INT_MASK  = 4'h5,
        REG_RX_DATA   = 4'h6,
        REG_RX_CTRL   = 4'h7,
        REG_TX_DATA   = 4'h8,
        REG_TX_CTRL   = 4'h9
    } cd_csr_addr_e;

    typedef struct packed {
        logic [15:0] div;
        logic [7:0]  idle_wait_len;
        logic [7:0]  filter;            // own address
    } cd_ctrl_t;

    typedef struct packed {
        logic bus_idle;                 // bit 4
        logic rx_pending;
        logic rx_lost;                  // sticky
        logic rx_error;                 // sticky
        logic tx_clean;                 // bit 0
    } cd_int_t;

endpackage

/* verilog/cd_frame_pkg.sv */
package cd_frame_pkg;

    typedef struct packed {
        logic       valid;
        logic       frame_end;
        logic [7:0] data;
    } cd_des_t;

    typedef struct packed {
        logic       en;
        logic [7:0] data;
        logic       commit;
        logic       abort;
    } cd_buf_wr_t;

    typedef struct packed {
        logic en;
        logic done;
    } cd_buf_rd_t;

    typedef struct packed {
        logic       pending;
        logic [7:0] len;
    } cd_buf_stat_t;

    typedef enum logic [1:0] {DES_IDLE, DES_START, DES_DATA, DES_STOP} cd_des_state_e;

    typedef enum logic [2:0] {
        SER_IDLE, SER_WAIT_IDLE, SER_START, SER_DATA, SER_STOP, SER_DONE
    } cd_ser_state_e;

    // crc-16/modbus over one byte lsb first
    function automatic logic [15:0] crc16_byte(input logic [15:0] crc, input logic [7:0] data);
        logic [15:0] c;
        c = crc ^ {8'h00, data};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ 16'ha001) : (c >> 1);
        end
        return c;
    endfunction

endpackage

/* verilog/cd_frame_buf.sv */
`timescale 1ns/1ps
`include "cdbus_cfg.svh"

module cd_frame_buf (
    input  logic                        clk,
    input  logic                        arst_n,
    input  cd_frame_pkg::cd_buf_wr_t    wr,
    input  cd_frame_pkg::cd_buf_rd_t    rd,
    output logic [7:0]                  rd_byte,
    output cd_frame_pkg::cd_buf_stat_t  stat
);

    logic [7:0]            mem [2**`CD_BUF_AW];
    logic [`CD_BUF_AW-1:0] wr_ptr;
    logic [`CD_BUF_AW-1:0] rd_ptr;
    logic                  pending;
    logic [7:0]            len;

    assign stat = '{pending: pending, len: len};

    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr_ptr] <= wr.data;
        end
        rd_byte <= mem[rd_ptr];             // one cycle behind the pointer
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            pending <= 1'b0;
            len <= '0;
        end else if (rd.done) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            pending <= 1'b0;
        end else begin
            if (wr.abort) begin
                wr_ptr <= '0;
            end else if (wr.en) begin
                wr_ptr <= wr_ptr + `CD_BUF_AW'(1);
            end
            if (wr.commit) begin
                pending <= 1'b1;
                len <= 8'(wr_ptr);
            end
            if (rd.en) begin
                rd_ptr <= rd_ptr + `CD_BUF_AW'(1);
            end
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n) wr.en |-> !pending)
        else $error("byte written into a pending buffer");
    assert property (@(posedge clk) disable iff (!arst_n) rd.en |-> pending)
        else $error("byte read from a buffer that is not pending");

endmodule

/* verilog/cd_rx_des.sv */
`timescale 1ns/1ps

module cd_rx_des (
    input  logic                   clk,
    input  logic                   arst_n,
    input  cd_reg_pkg::cd_ctrl_t   ctrl,
    input  logic                   rx,
    output cd_frame_pkg::cd_des_t  des,
    output logic                   bus_idle
);
    import cd_frame_pkg::*;

    logic [1:0]    rx_sync;
    logic          rx_s;
    cd_des_state_e state;
    logic [15:0]   cnt;
    logic [2:0]    bit_idx;
    logic [7:0]    shreg;
    logic          byte_vld;
    logic [7:0]    byte_data;
    logic          frame_end;
    logic [15:0]   idle_cnt;
    logic [7:0]    idle_bits;
    logic          got_byte;

    assign rx_s = rx_sync[1];
    assign des = '{valid: byte_vld, frame_end: frame_end, data: byte_data};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rx_sync <= 2'b11;               // line idles high
        end else begin
            rx_sync <= {rx_sync[0], rx};
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // byte sampler

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= DES_IDLE;
            cnt <= '0;
            bit_idx <= '0;
            shreg <= '0;
            byte_vld <= 1'b0;
            byte_data <= '0;
        end else begin
            byte_vld <= 1'b0;
            cnt <= cnt + 16'd1;
            case (state)
                DES_IDLE: begin
                    cnt <= '0;
                    if (!rx_s) begin
                        state <= DES_START;
                    end
                end
                DES_START: if (cnt == {1'b0, ctrl.div[15:1]}) begin
                    cnt <= '0;
                    bit_idx <= '0;
                    state <= rx_s ? DES_IDLE : DES_DATA;    // glitch rejects
                end
                DES_DATA: if (cnt == ctrl.div) begin
                    cnt <= '0;
                    shreg <= {rx_s, shreg[7:1]};            // lsb first
                    bit_idx <= bit_idx + 3'd1;
                    if (bit_idx == 3'd7) begin
                        state <= DES_STOP;
                    end
                end
                DES_STOP: if (cnt == ctrl.div) begin
                    state <= DES_IDLE;
                    byte_vld <= rx_s;                       // bad stop drops byte
                    byte_data <= shreg;
                end
                default: state <= DES_IDLE;
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // idle detection

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            idle_cnt <= '0;
            idle_bits <= '0;
            bus_idle <= 1'b0;
            frame_end <= 1'b0;
            got_byte <= 1'b0;
        end else begin
            frame_end <= 1'b0;
            if (byte_vld) begin
                got_byte <= 1'b1;
            end
            if (!rx_s || state != DES_IDLE) begin
                idle_cnt <= '0;
                idle_bits <= '0;
                bus_idle <= 1'b0;
            end else if (!bus_idle) begin
                if (idle_cnt == ctrl.div) begin
                    idle_cnt <= '0;
                    idle_bits <= idle_bits + 8'd1;
                end else begin
                    idle_cnt <= idle_cnt + 16'd1;
                end
                if (idle_bits == ctrl.idle_wait_len) begin
                    bus_idle <= 1'b1;
                    frame_end <= got_byte;
                    got_byte <= 1'b0;
                end
            end
        end
    end

endmodule

/* verilog/cd_rx_bytes.sv */
`timescale 1ns/1ps

module cd_rx_bytes (
    input  logic                      clk,
    input  logic                      arst_n,
    input  cd_reg_pkg::cd_ctrl_t      ctrl,
    input  cd_frame_pkg::cd_des_t     des,
    input  logic                      buf_pending,
    output cd_frame_pkg::cd_buf_wr_t  wr,
    output logic                      err,
    output logic                      lost
);
    import cd_frame_pkg::*;

    logic [8:0]  cnt;
    logic [15:0] crc;
    logic [7:0]  dst;
    logic [7:0]  len_b;
    logic        drop;                  // buffer was busy at frame start
    logic        skip;
    logic        filter_ok;
    logic        crc_ok;
    logic        len_ok;

    assign skip = (cnt == 9'd0) ? buf_pending : drop;
    assign filter_ok = dst == ctrl.filter || dst == 8'hff;
    assign crc_ok = crc == 16'h0000;    // residue over data and crc
    assign len_ok = cnt == {1'b0, len_b} + 9'd5;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt <= '0;
            crc <= 16'hffff;
            dst <= '0;
            len_b <= '0;
            drop <= 1'b0;
            wr <= '0;
            err <= 1'b0;
            lost <= 1'b0;
        end else begin
            wr <= '0;
            err <= 1'b0;
            lost <= 1'b0;
            if (des.valid) begin
                cnt <= cnt + 9'd1;
                crc <= crc16_byte(crc, des.data);
                if (cnt == 9'd0) begin
                    drop <= buf_pending;
                end
                if (cnt == 9'd1) begin
                    dst <= des.data;
                end
                if (cnt == 9'd2) begin
                    len_b <= des.data;
                end
                wr.en <= !skip;
                wr.data <= des.data;
            end
            if (des.frame_end) begin
                cnt <= '0;
                crc <= 16'hffff;
                drop <= 1'b0;
                if (drop) begin
                    lost <= 1'b1;
                end else if (filter_ok && crc_ok && len_ok) begin
                    wr.commit <= 1'b1;
                end else begin
                    wr.abort <= 1'b1;
                    err <= !(crc_ok && len_ok);     // filter miss is silent
                end
            end
        end
    end

endmodule

/* verilog/cd_tx_ser.sv */
`timescale 1ns/1ps

module cd_tx_ser (
    input  logic                        clk,
    input  logic                        arst_n,
    input  cd_reg_pkg::cd_ctrl_t        ctrl,
    input  logic                        bus_idle,
    input  cd_frame_pkg::cd_buf_stat_t  stat,
    output cd_frame_pkg::cd_buf_rd_t    rd,
    input  logic [7:0]                  rd_byte,
    output logic                        tx,
    output logic                        tx_en
);
    import cd_frame_pkg::*;

    cd_ser_state_e state;
    logic [15:0]   cnt;
    logic [2:0]    bit_idx;
    logic [7:0]    shreg;
    logic [15:0]   crc;
    logic [7:0]    sent;
    logic [1:0]    phase;               // 0 data, 1 crc low, 2 crc high
    logic          bit_end;

    assign bit_end = cnt == ctrl.div;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= SER_IDLE;
            cnt <= '0;
            bit_idx <= '0;
            shreg <= '0;
            crc <= 16'hffff;
            sent <= '0;
            phase <= '0;
            rd <= '0;
            tx <= 1'b1;
            tx_en <= 1'b0;
        end else begin
            rd <= '0;
            cnt <= bit_end ? 16'd0 : cnt + 16'd1;
            case (state)
                SER_IDLE: if (stat.pending) begin
                    state <= SER_WAIT_IDLE;
                end
                SER_WAIT_IDLE: begin
                    cnt <= '0;
                    if (bus_idle) begin
                        state <= SER_START;
                        shreg <= rd_byte;
                        crc <= crc16_byte(16'hffff, rd_byte);
                        sent <= 8'd1;
                        phase <= 2'd0;
                        rd.en <= 1'b1;
                        tx <= 1'b0;
                        tx_en <= 1'b1;
                    end
                end
                SER_START: if (bit_end) begin
                    state <= SER_DATA;
                    bit_idx <= '0;
                    tx <= shreg[0];
                end
                SER_DATA: if (bit_end) begin
                    bit_idx <= bit_idx + 3'd1;
                    shreg <= shreg >> 1;
                    tx <= shreg[1];
                    if (bit_idx == 3'd7) begin
                        state <= SER_STOP;
                        tx <= 1'b1;
                    end
                end
                SER_STOP: if (bit_end) begin
                    state <= SER_START;
                    tx <= 1'b0;
                    if (phase == 2'd0 && sent != stat.len) begin
                        shreg <= rd_byte;
                        crc <= crc16_byte(crc, rd_byte);
                        sent <= sent + 8'd1;
                        rd.en <= 1'b1;
                    end else if (phase == 2'd0) begin
                        phase <= 2'd1;
                        shreg <= crc[7:0];
                    end else if (phase == 2'd1) begin
                        phase <= 2'd2;
                        shreg <= crc[15:8];
                    end else begin
                        state <= SER_DONE;
                        tx <= 1'b1;
                        tx_en <= 1'b0;      // end of last stop bit
                        rd.done <= 1'b1;
                    end
                end
                SER_DONE: state <= SER_IDLE;            // buffer drops pending here
                default: state <= SER_IDLE;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n) state == SER_IDLE |-> !tx_en)
        else $error("tx_en high while serializer idle");

endmodule

/* verilog/cd_csr.sv */
`timescale 1ns/1ps
`include "cdbus_cfg.svh"

module cd_csr (
    input  logic                        clk,
    input  logic                        arst_n,
    input  cd_reg_pkg::cd_csr_addr_e    csr_address,
    input  logic                        csr_read,
    input  logic                        csr_write,
    input  logic [31:0]                 csr_writedata,
    output logic [31:0]                 csr_readdata,
    output logic                        irq,
    output cd_reg_pkg::cd_ctrl_t        ctrl,
    input  logic                        bus_idle,
    input  logic                        rx_err,
    input  logic                        rx_lost,
    output cd_frame_pkg::cd_buf_rd_t    rx_wr,
    input  logic [7:0]                  rx_byte,
    input  cd_frame_pkg::cd_buf_stat_t  rx_stat,
    output cd_frame_pkg::cd_buf_wr_t    tx_wr,
    input  cd_frame_pkg::cd_buf_stat_t  tx_stat
);
    import cd_reg_pkg::*;

    cd_int_t int_flag;
    cd_int_t int_mask;
    cd_int_t flag_clr;
    logic    rx_lost_r;
    logic    rx_err_r;

    assign int_flag = '{bus_idle:   bus_idle,
                        rx_pending: rx_stat.pending,
                        rx_lost:    rx_lost_r,
                        rx_error:   rx_err_r,
                        tx_clean:   ~tx_stat.pending};
    assign irq = |(int_flag & int_mask);

    assign flag_clr = (csr_write && csr_address == REG_INT_FLAG) ? csr_writedata[4:0] : '0;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // buffer strobes

    always_comb begin
        rx_wr = '0;
        tx_wr = '0;
        rx_wr.en = csr_read && csr_address == REG_RX_DATA && rx_stat.pending;
        rx_wr.done = csr_write && csr_address == REG_RX_CTRL &&
                     (csr_writedata[1] || (csr_writedata[0] && rx_stat.pending));
        tx_wr.data = csr_writedata[7:0];
        if (csr_write && !tx_stat.pending) begin    // frame locked once committed
            tx_wr.en = csr_address == REG_TX_DATA;
            tx_wr.commit = csr_address == REG_TX_CTRL && csr_writedata[0];
            tx_wr.abort = csr_address == REG_TX_CTRL && csr_writedata[1];
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // control registers and sticky flags

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ctrl.div <= `CD_DIV_RESET;
            ctrl.idle_wait_len <= `CD_IDLE_RESET;
            ctrl.filter <= `CD_FILTER_RESET;
            int_mask <= '0;
            rx_lost_r <= 1'b0;
            rx_err_r <= 1'b0;
        end else begin
            if (csr_write) begin
                case (csr_address)
                    REG_DIV:       ctrl.div <= csr_writedata[15:0];
                    REG_IDLE_WAIT: ctrl.idle_wait_len <= csr_writedata[7:0];
                    REG_FILTER:    ctrl.filter <= csr_writedata[7:0];
                    REG_INT_MASK:  int_mask <= csr_writedata[4:0];
                    default: ;
                endcase
            end
            if (rx_lost) begin
                rx_lost_r <= 1'b1;          // set wins over clear
            end else if (flag_clr.rx_lost) begin
                rx_lost_r <= 1'b0;
            end
            if (rx_err) begin
                rx_err_r <= 1'b1;
            end else if (flag_clr.rx_error) begin
                rx_err_r <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (csr_read) begin
            case (csr_address)
                REG_VERSION:   csr_readdata <= {24'd0, `CD_VERSION};
                REG_DIV:       csr_readdata <= {16'd0, ctrl.div};
                REG_IDLE_WAIT: csr_readdata <= {24'd0, ctrl.idle_wait_len};
                REG_FILTER:    csr_readdata <= {24'd0, ctrl.filter};
                REG_INT_FLAG:  csr_readdata <= {27'd0, int_flag};
                REG_INT_MASK:  csr_readdata <= {27'd0, int_mask};
                REG_RX_DATA:   csr_readdata <= {24'd0, rx_byte};
                REG_RX_CTRL:   csr_readdata <= {23'd0, rx_stat};   // pending, len
                REG_TX_CTRL:   csr_readdata <= {23'd0, tx_stat};
                default:       csr_readdata <= '0;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n) !(csr_read && csr_write))
        else $error("csr read and write in the same cycle");

endmodule

/* verilog/cdbus.sv */
`timescale 1ns/1ps

module cdbus (
    input  logic                      clk,
    input  logic                      arst_n,
    input  cd_reg_pkg::cd_csr_addr_e  csr_address,
    input  logic                      csr_read,
    input  logic                      csr_write,
    input  logic [31:0]               csr_writedata,
    output logic [31:0]               csr_readdata,
    output logic                      irq,
    input  logic                      rx,
    output logic                      tx,
    output logic                      tx_en
);
    import cd_reg_pkg::*;
    import cd_frame_pkg::*;

    cd_ctrl_t     ctrl;
    cd_des_t      des;
    logic         bus_idle;
    logic         rx_err;
    logic         rx_lost;
    cd_buf_wr_t   rx_buf_wr;
    cd_buf_rd_t   rx_buf_rd;
    cd_buf_stat_t rx_buf_stat;
    logic [7:0]   rx_buf_byte;
    cd_buf_wr_t   tx_buf_wr;
    cd_buf_rd_t   tx_buf_rd;
    cd_buf_stat_t tx_buf_stat;
    logic [7:0]   tx_buf_byte;

    cd_csr csr_i (
        .clk(clk), .arst_n(arst_n),
        .csr_address(csr_address), .csr_read(csr_read), .csr_write(csr_write),
        .csr_writedata(csr_writedata), .csr_readdata(csr_readdata), .irq(irq),
        .ctrl(ctrl), .bus_idle(bus_idle), .rx_err(rx_err), .rx_lost(rx_lost),
        .rx_wr(rx_buf_rd), .rx_byte(rx_buf_byte), .rx_stat(rx_buf_stat),
        .tx_wr(tx_buf_wr), .tx_stat(tx_buf_stat)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // receive path

    cd_rx_des rx_des_i (
        .clk(clk), .arst_n(arst_n), .ctrl(ctrl), .rx(rx),
        .des(des), .bus_idle(bus_idle)
    );

    cd_rx_bytes rx_bytes_i (
        .clk(clk), .arst_n(arst_n), .ctrl(ctrl), .des(des),
        .buf_pending(rx_buf_stat.pending), .wr(rx_buf_wr), .err(rx_err), .lost(rx_lost)
    );

    cd_frame_buf rx_buf_i (
        .clk(clk), .arst_n(arst_n), .wr(rx_buf_wr), .rd(rx_buf_rd),
        .rd_byte(rx_buf_byte), .stat(rx_buf_stat)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // transmit path

    cd_frame_buf tx_buf_i (
        .clk(clk), .arst_n(arst_n), .wr(tx_buf_wr), .rd(tx_buf_rd),
        .rd_byte(tx_buf_byte), .stat(tx_buf_stat)
    );

    cd_tx_ser tx_ser_i (
        .clk(clk), .arst_n(arst_n), .ctrl(ctrl), .bus_idle(bus_idle),
        .stat(tx_buf_stat), .rd(tx_buf_rd), .rd_byte(tx_buf_byte),
        .tx(tx), .tx_en(tx_en)
    );

endmodule

/* dv/cdbus_tb.sv */
`timescale 1ns/1ps
`include "cdbus_cfg.svh"

module cdbus_tb;
    import cd_reg_pkg::*;

    localparam int BIT_CLKS = 8;            // div 7

    logic         clk;
    logic         arst_n;
    cd_csr_addr_e csr_address;
    logic         csr_read;
    logic         csr_write;
    logic [31:0]  csr_writedata;
    logic [31:0]  csr_readdata;
    logic         irq;
    logic         rx;
    logic         tx;
    logic         tx_en;
    logic         rx_drv;
    logic         loopback;
    logic [7:0]   own_addr;
    logic [7:0]   frame_q [$];              // header, data, crc low, crc high
    int unsigned  seed_val;

    assign rx = loopback ? tx : rx_drv;

    cdbus dut_i (
        .clk(clk), .arst_n(arst_n),
        .csr_address(csr_address), .csr_read(csr_read), .csr_write(csr_write),
        .csr_writedata(csr_writedata), .csr_readdata(csr_readdata), .irq(irq),
        .rx(rx), .tx(tx), .tx_en(tx_en)
    );

    always #50 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // compare tasks

    task automatic abort_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (exp !== act) begin
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_int(input string name, input cd_int_t exp, input cd_int_t act);
        if (exp !== act) begin
            $display("FAIL %s: expected %b, actual %b", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_len(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (exp !== act) begin
            $display("FAIL %s: expected %0d, actual %0d", name, exp, act);
            abort_run();
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model

    function automatic logic [15:0] model_crc();
        logic [15:0] c;
        logic        fb;
        c = 16'hffff;
        foreach (frame_q[i]) begin
            for (int j = 0; j < 8; j++) begin
                fb = c[0] ^ frame_q[i][j];      // bit-serial lfsr
                c = c >> 1;
                if (fb) begin
                    c = c ^ 16'ha001;           // reflected poly
                end
            end
        end
        return c;
    endfunction

    function automatic logic filter_match(input logic [7:0] dst, input logic [7:0] own);
        return dst == own || dst == 8'hff;  // ff is broadcast
    endfunction

    function automatic cd_int_t idle_flags(input logic pend, input logic lost, input logic err);
        return '{bus_idle: 1'b1, rx_pending: pend, rx_lost: lost, rx_error: err, tx_clean: 1'b1};
    endfunction

    task automatic build_frame(input logic [7:0] dst, input int len);
        logic [15:0] crc;
        frame_q.delete();
        frame_q.push_back(8'($urandom));    // source
        frame_q.push_back(dst);
        frame_q.push_back(8'(len));
        for (int i = 0; i < len; i++) begin
            frame_q.push_back(8'($urandom));
        end
        crc = model_crc();
        frame_q.push_back(crc[7:0]);
        frame_q.push_back(crc[15:8]);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // host port

    task automatic csr_wr(input cd_csr_addr_e a, input logic [31:0] d);
        @(posedge clk);
        #1;
        csr_address = a;
        csr_writedata = d;
        csr_write = 1'b1;
        @(posedge clk);
        #1;
        csr_write = 1'b0;
    endtask

    task automatic csr_rd(input cd_csr_addr_e a, output logic [31:0] d);
        @(posedge clk);
        #1;
        csr_address = a;
        csr_read = 1'b1;
        @(posedge clk);
        #1;
        csr_read = 1'b0;
        d = csr_readdata;                   // registered and valid after the edge
    endtask

    task automatic check_flags(input string name, input cd_int_t exp);
        logic [31:0] d;
        csr_rd(REG_INT_FLAG, d);
        check_int(name, exp, cd_int_t'(d[4:0]));
    endtask

    task automatic wait_bus_idle();
        logic [31:0] d;
        int t;
        t = 0;
        d = '0;
        while (!d[4]) begin
            if (t == 500) begin
                $display("timeout waiting for the bus to go idle");
                abort_run();
            end
            csr_rd(REG_INT_FLAG, d);
            t++;
        end
        repeat (4) @(posedge clk);          // commit lags bus_idle
    endtask

    task automatic check_rx_frame(input string name);
        logic [31:0] d;
        csr_rd(REG_RX_CTRL, d);
        check_byte({name, " pending"}, 8'd1, {7'd0, d[8]});
        check_len({name, " length"}, 8'(frame_q.size()), d[7:0]);
        foreach (frame_q[k]) begin
            csr_rd(REG_RX_DATA, d);
            check_byte($sformatf("%s byte %0d", name, k), frame_q[k], d[7:0]);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // serial line

    task automatic drive_rx_bit(input logic v);
        rx_drv = v;
        repeat (BIT_CLKS) @(posedge clk);
        #1;
    endtask

    task automatic send_frame();
        @(posedge clk);
        #1;
        foreach (frame_q[k]) begin
            drive_rx_bit(1'b0);
            for (int i = 0; i < 8; i++) begin
                drive_rx_bit(frame_q[k][i]);    // lsb first
            end
            drive_rx_bit(1'b1);
        end
    endtask

    task automatic tx_bit_wait(input int n);
        repeat (n) begin
            @(negedge clk);
            check_byte("tx_en during frame", 8'd1, {7'd0, tx_en});
        end
    endtask

    task automatic decode_tx_byte(input bit first, output logic [7:0] b);
        int t;
        t = 0;
        while (tx !== 1'b0) begin
            if (t == 2000) begin
                $display("timeout waiting for a start bit on tx");
                abort_run();
            end
            @(negedge clk);
            if (!first) begin
                check_byte("tx_en between bytes", 8'd1, {7'd0, tx_en});
            end
            t++;
        end
        tx_bit_wait(BIT_CLKS / 2);          // to mid-bit
        check_byte("tx start bit", 8'd0, {7'd0, tx});
        for (int i = 0; i < 8; i++) begin
            tx_bit_wait(BIT_CLKS);
            b[i] = tx;
        end
        tx_bit_wait(BIT_CLKS);
        check_byte("tx stop bit", 8'd1, {7'd0, tx});
    endtask

    task automatic decode_tx_frame();
        logic [7:0] b;
        int t;
        foreach (frame_q[k]) begin
            decode_tx_byte(k == 0, b);
            check_byte($sformatf("tx byte %0d", k), frame_q[k], b);
        end
        t = 0;
        while (tx_en !== 1'b0) begin
            if (t == 2 * BIT_CLKS) begin
                $display("timeout waiting for tx_en to fall after the frame");
                abort_run();
            end
            @(negedge clk);
            t++;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // tests

    task automatic run_loopback();
        logic [7:0] dst;
        dst = ($urandom % 2) ? own_addr : 8'hff;
        build_frame(dst, $urandom_range(12, 0));
        csr_wr(REG_INT_MASK, 32'h08);       // rx_pending only
        loopback = 1'b1;
        for (int k = 0; k < frame_q.size() - 2; k++) begin
            csr_wr(REG_TX_DATA, {24'd0, frame_q[k]});
        end
        csr_wr(REG_TX_CTRL, 32'h1);
        decode_tx_frame();
        wait_bus_idle();
        check_flags("loopback flags", idle_flags(filter_match(dst, own_addr), 1'b0, 1'b0));
        check_byte("irq on rx_pending", 8'd1, {7'd0, irq});
        check_rx_frame("loopback rx");
        csr_wr(REG_RX_CTRL, 32'h1);
        check_flags("rx buffer released", idle_flags(1'b0, 1'b0, 1'b0));
        check_byte("irq after release", 8'd0, {7'd0, irq});
        csr_wr(REG_INT_MASK, 32'h0);
        loopback = 1'b0;
    endtask

    initial begin
        logic [31:0] d;
        logic [15:0] v16;
        logic [7:0]  v8;
        logic [7:0]  other;
        seed_val = $urandom(32'h9385_50dc);
        clk = 1'b0;
        arst_n = 1'b0;
        csr_address = REG_VERSION;
        csr_read = 1'b0;
        csr_write = 1'b0;
        csr_writedata = '0;
        rx_drv = 1'b1;
        loopback = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        arst_n = 1'b1;

        check_byte("reset tx", 8'd1, {7'd0, tx});
        check_byte("reset tx_en", 8'd0, {7'd0, tx_en});
        check_byte("reset irq", 8'd0, {7'd0, irq});
        csr_wr(REG_DIV, 32'd7);             // before the idle counter passes 7
        csr_wr(REG_IDLE_WAIT, 32'd3);
        wait_bus_idle();

        csr_rd(REG_VERSION, d);
        check_byte("VERSION", `CD_VERSION, d[7:0]);
        v16 = 16'($urandom);                // counters hold while the bus is idle
        csr_wr(REG_DIV, {16'd0, v16});
        csr_rd(REG_DIV, d);
        check_byte("DIV low", v16[7:0], d[7:0]);
        check_byte("DIV high", v16[15:8], d[15:8]);
        v8 = 8'($urandom);
        csr_wr(REG_IDLE_WAIT, {24'd0, v8});
        csr_rd(REG_IDLE_WAIT, d);
        check_byte("IDLE_WAIT", v8, d[7:0]);
        v8 = 8'($urandom);
        csr_wr(REG_FILTER, {24'd0, v8});
        csr_rd(REG_FILTER, d);
        check_byte("FILTER", v8, d[7:0]);
        v8 = 8'($urandom) & 8'h1f;
        csr_wr(REG_INT_MASK, {24'd0, v8});
        csr_rd(REG_INT_MASK, d);
        check_byte("INT_MASK", v8, d[7:0]);
        own_addr = 8'($urandom_range(8'hfe, 0));
        csr_wr(REG_DIV, 32'd7);
        csr_wr(REG_IDLE_WAIT, 32'd3);
        csr_wr(REG_FILTER, {24'd0, own_addr});
        csr_wr(REG_INT_MASK, 32'h0);

        repeat (3) run_loopback();

        other = 8'($urandom_range(8'hfd, 0));
        if (other >= own_addr) begin
            other = other + 8'd1;           // skips own address and never reaches ff
        end
        build_frame(other, $urandom_range(12, 0));
        send_frame();
        wait_bus_idle();
        check_flags("filter miss", idle_flags(filter_match(other, own_addr), 1'b0, 1'b0));

        build_frame(own_addr, $urandom_range(12, 0));
        frame_q[frame_q.size() - 2] ^= 8'($urandom_range(255, 1));
        send_frame();
        wait_bus_idle();
        check_flags("crc error", idle_flags(1'b0, 1'b0, 1'b1));
        build_frame(own_addr, $urandom_range(12, 0));
        send_frame();
        wait_bus_idle();
        check_flags("frame stored", idle_flags(1'b1, 1'b0, 1'b1));
        build_frame(8'hff, $urandom_range(12, 0));
        send_frame();
        wait_bus_idle();
        check_flags("frame lost", idle_flags(1'b1, 1'b1, 1'b1));
        csr_wr(REG_INT_FLAG, 32'h1f);
        check_flags("sticky flags cleared", idle_flags(1'b1, 1'b0, 1'b0));
        csr_wr(REG_RX_CTRL, 32'h2);
        check_flags("rx buffer cleared", idle_flags(1'b0, 1'b0, 1'b0));

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* flist.f */
+incdir+verilog
verilog/cd_reg_pkg.sv
verilog/cd_frame_pkg.sv
verilog/cd_frame_buf.sv
verilog/cd_rx_des.sv
verilog/cd_rx_bytes.sv
verilog/cd_tx_ser.sv
verilog/cd_csr.sv
verilog/cdbus.sv
dv/cdbus_tb.sv
